/* build.f */
+incdir+src
src/axi_chan_pkg.sv
src/lrsc_pkg.sv
src/sync_fifo.sv
src/res_table.sv
src/read_path.sv
src/write_path.sv
src/resp_merge.sv
src/lrsc_adapter.sv
verification/tb_lrsc_adapter.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_lrsc_adapter
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  := All tests passed!

SOURCES := $(wildcard src/*.sv src/*.svh verification/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/tb_lrsc_adapter.sv */
`timescale 1ns/1ns
`include "lrsc_settings.svh"

module tb_lrsc_adapter
    import axi_chan_pkg::*;
    import lrsc_pkg::*;
();

    localparam int    NUM_TESTS       = 6;
    localparam int    CYCLES_PER_TEST = 200;
    localparam addr_t ERR_ADDR        = 16'h1FFC;
    localparam int    MEM_WORDS       = 2 ** (`LRSC_ADDR_WIDTH - 2);

    logic     clk_i;
    logic     rst_ni;
    ar_chan_t slv_ar_i;
    logic     slv_ar_valid_i;
    logic     slv_ar_ready_o;
    aw_chan_t slv_aw_i;
    logic     slv_aw_valid_i;
    logic     slv_aw_ready_o;
    w_chan_t  slv_w_i;
    logic     slv_w_valid_i;
    logic     slv_w_ready_o;
    r_chan_t  slv_r_o;
    logic     slv_r_valid_o;
    logic     slv_r_ready_i;
    b_chan_t  slv_b_o;
    logic     slv_b_valid_o;
    logic     slv_b_ready_i;
    ar_chan_t mst_ar_o;
    logic     mst_ar_valid_o;
    logic     mst_ar_ready_i = 1'b0;
    aw_chan_t mst_aw_o;
    logic     mst_aw_valid_o;
    logic     mst_aw_ready_i = 1'b0;
    w_chan_t  mst_w_o;
    logic     mst_w_valid_o;
    logic     mst_w_ready_i  = 1'b0;
    r_chan_t  mst_r_i        = '0;
    logic     mst_r_valid_i  = 1'b0;
    logic     mst_r_ready_o;
    b_chan_t  mst_b_i        = '0;
    logic     mst_b_valid_i  = 1'b0;
    logic     mst_b_ready_o;

    // Expected responses are filled by the stimulus and consumed on handshakes
    data_t      exp_r_data [256];
    id_t        exp_r_id   [256];
    logic [1:0] exp_r_resp [256];
    id_t        exp_b_id   [256];
    logic [1:0] exp_b_resp [256];
    int         r_wr_ptr = 0;
    int         r_rd_ptr = 0;
    int         b_wr_ptr = 0;
    int         b_rd_ptr = 0;

    // Reference memory contents and reservations per id
    data_t      ref_mem [MEM_WORDS];
    logic       res_valid [4];
    word_addr_t res_word [4];

    // Slave model state
    data_t   mem [MEM_WORDS];
    r_chan_t rd_q[$];
    b_chan_t wb_q[$];

    logic drop_expected = 1'b0;
    int   error_count   = 0;
    int   test_count    = 0;
    int   pass_count    = 0;
    int   errors_before = 0;

    wire        r_hs = slv_r_valid_o && slv_r_ready_i;
    wire        b_hs = slv_b_valid_o && slv_b_ready_i;
    wire [31:0] r_data_got = slv_r_o.data;
    wire [31:0] r_data_exp = exp_r_data[r_rd_ptr];
    wire [1:0]  r_id_got   = slv_r_o.id;
    wire [1:0]  r_id_exp   = exp_r_id[r_rd_ptr];
    wire [1:0]  r_resp_got = slv_r_o.resp;
    wire [1:0]  r_resp_exp = exp_r_resp[r_rd_ptr];
    wire [1:0]  b_id_got   = slv_b_o.id;
    wire [1:0]  b_id_exp   = exp_b_id[b_rd_ptr];
    wire [1:0]  b_resp_got = slv_b_o.resp;
    wire [1:0]  b_resp_exp = exp_b_resp[b_rd_ptr];

    lrsc_adapter i_dut (.*);

    function automatic data_t fill_word(int unsigned word);
        logic [15:0] byte_addr;
        byte_addr = 16'(word << 2);
        return {byte_addr ^ 16'h5A3C, ~byte_addr};
    endfunction

    function automatic logic excl_addr(addr_t addr);
        return (addr >= `LRSC_EXCL_BEGIN) && (addr <= `LRSC_EXCL_END);
    endfunction

    function automatic void mismatch(string name, logic [31:0] got, logic [31:0] expected);
        $display("Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, expected);
        error_count++;
    endfunction

    function automatic void problem(string what);
        $display("Failure at %0t ns: %s", $time, what);
        error_count++;
    endfunction

    a_r_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
        r_hs |-> (r_data_got == r_data_exp))
        else mismatch("slv_r_o.data", $sampled(r_data_got), $sampled(r_data_exp));
    a_r_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
        r_hs |-> (r_id_got == r_id_exp))
        else mismatch("slv_r_o.id", 32'($sampled(r_id_got)), 32'($sampled(r_id_exp)));
    a_r_resp: assert property (@(posedge clk_i) disable iff (!rst_ni)
        r_hs |-> (r_resp_got == r_resp_exp))
        else mismatch("slv_r_o.resp", 32'($sampled(r_resp_got)), 32'($sampled(r_resp_exp)));
    a_b_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
        b_hs |-> (b_id_got == b_id_exp))
        else mismatch("slv_b_o.id", 32'($sampled(b_id_got)), 32'($sampled(b_id_exp)));
    a_b_resp: assert property (@(posedge clk_i) disable iff (!rst_ni)
        b_hs |-> (b_resp_got == b_resp_exp))
        else mismatch("slv_b_o.resp", 32'($sampled(b_resp_got)), 32'($sampled(b_resp_exp)));
    a_r_wanted: assert property (@(posedge clk_i) disable iff (!rst_ni)
        slv_r_valid_o |-> (r_rd_ptr != r_wr_ptr))
        else problem("a read response came with no read outstanding");
    a_b_wanted: assert property (@(posedge clk_i) disable iff (!rst_ni)
        slv_b_valid_o |-> (b_rd_ptr != b_wr_ptr))
        else problem("a write response came with no write outstanding");
    a_ar_unlocked: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mst_ar_valid_o |-> !mst_ar_o.lock)
        else problem("the slave saw a locked read");
    a_aw_unlocked: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mst_aw_valid_o |-> !mst_aw_o.lock)
        else problem("the slave saw a locked write");
    // AW and W travel as one transfer on both sides
    a_aw_w_joined: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (slv_aw_ready_o == slv_w_ready_o) && (mst_aw_valid_o == mst_w_valid_o))
        else problem("the AW and W channels were not handled together");
    // A failed store-conditional must never reach memory
    a_drop_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (slv_aw_valid_i && drop_expected) |-> !mst_aw_valid_o)
        else problem("a store-conditional without reservation was forwarded");

    always @(posedge clk_i) begin
        if (rst_ni && r_hs) begin
            r_rd_ptr <= r_rd_ptr + 1;
        end
        if (rst_ni && b_hs) begin
            b_rd_ptr <= b_rd_ptr + 1;
        end
    end

    // In-order memory slave that answers SLVERR at one address
    always @(posedge clk_i) begin
        r_chan_t rsp;
        b_chan_t bsp;
        if (mst_r_valid_i && mst_r_ready_o) begin
            void'(rd_q.pop_front());
        end
        if (mst_b_valid_i && mst_b_ready_o) begin
            void'(wb_q.pop_front());
        end
        if (mst_ar_valid_o && mst_ar_ready_i) begin
            rsp.id   = mst_ar_o.id;
            rsp.resp = (mst_ar_o.addr == ERR_ADDR) ? SLVERR : OKAY;
            rsp.data = (mst_ar_o.addr == ERR_ADDR) ? '0 : mem[mst_ar_o.addr[15:2]];
            rd_q.push_back(rsp);
        end
        if (mst_aw_valid_o && mst_aw_ready_i && mst_w_valid_o && mst_w_ready_i) begin
            bsp.id   = mst_aw_o.id;
            bsp.resp = (mst_aw_o.addr == ERR_ADDR) ? SLVERR : OKAY;
            if (mst_aw_o.addr != ERR_ADDR) begin
                for (int b = 0; b < STRB_WIDTH; b++) begin
                    if (mst_w_o.strb[b]) begin
                        mem[mst_aw_o.addr[15:2]][8*b +: 8] = mst_w_o.data[8*b +: 8];
                    end
                end
            end
            wb_q.push_back(bsp);
        end
    end

    always @(negedge clk_i) begin
        mst_ar_ready_i = ($urandom_range(3) != 0);
        mst_aw_ready_i = ($urandom_range(3) != 0);
        mst_w_ready_i  = mst_aw_ready_i;
        if ((rd_q.size() > 0) && (mst_r_valid_i || ($urandom_range(2) != 0))) begin
            mst_r_valid_i = 1'b1;
            mst_r_i       = rd_q[0];
        end else begin
            mst_r_valid_i = 1'b0;
            mst_r_i       = '0;
        end
        if ((wb_q.size() > 0) && (mst_b_valid_i || ($urandom_range(2) != 0))) begin
            mst_b_valid_i = 1'b1;
            mst_b_i       = wb_q[0];
        end else begin
            mst_b_valid_i = 1'b0;
            mst_b_i       = '0;
        end
        if (rst_ni) begin
            slv_r_ready_i = ($urandom_range(3) != 0);
            slv_b_ready_i = ($urandom_range(3) != 0);
        end
    end

    task automatic read_word(input id_t id, input addr_t addr, input logic lock);
        logic excl;
        excl = lock && excl_addr(addr);
        exp_r_id[r_wr_ptr]   = id;
        exp_r_data[r_wr_ptr] = (addr == ERR_ADDR) ? '0 : ref_mem[addr[15:2]];
        if (addr == ERR_ADDR) begin
            exp_r_resp[r_wr_ptr] = SLVERR;
        end else begin
            exp_r_resp[r_wr_ptr] = excl ? EXOKAY : OKAY;
        end
        r_wr_ptr++;
        // The reservation is taken even when the slave answers with an error
        if (excl) begin
            res_valid[id] = 1'b1;
            res_word[id]  = addr[15:2];
        end
        slv_ar_i.addr  = addr;
        slv_ar_i.id    = id;
        slv_ar_i.lock  = lock;
        slv_ar_valid_i = 1'b1;
        do @(posedge clk_i); while (!slv_ar_ready_o);
        @(negedge clk_i);
        slv_ar_valid_i = 1'b0;
        slv_ar_i       = '0;
    endtask

    task automatic write_word(input id_t id, input addr_t addr, input logic lock,
                              input data_t data);
        logic excl;
        logic fwd;
        excl = lock && excl_addr(addr);
        fwd  = !excl || (res_valid[id] && (res_word[id] == addr[15:2]));
        exp_b_id[b_wr_ptr] = id;
        if (!fwd) begin
            exp_b_resp[b_wr_ptr] = OKAY;
        end else if (addr == ERR_ADDR) begin
            exp_b_resp[b_wr_ptr] = SLVERR;
        end else begin
            exp_b_resp[b_wr_ptr] = excl ? EXOKAY : OKAY;
        end
        b_wr_ptr++;
        if (fwd && (addr != ERR_ADDR)) begin
            ref_mem[addr[15:2]] = data;
        end
        // Any accepted write in the range kills reservations on its word
        if (excl_addr(addr)) begin
            for (int i = 0; i < 4; i++) begin
                if (res_word[i] == addr[15:2]) begin
                    res_valid[i] = 1'b0;
                end
            end
        end
        drop_expected  = !fwd;
        slv_aw_i.addr  = addr;
        slv_aw_i.id    = id;
        slv_aw_i.lock  = lock;
        slv_w_i.data   = data;
        slv_w_i.strb   = '1;
        slv_aw_valid_i = 1'b1;
        slv_w_valid_i  = 1'b1;
        do @(posedge clk_i); while (!(slv_aw_ready_o && slv_w_ready_o));
        @(negedge clk_i);
        slv_aw_valid_i = 1'b0;
        slv_w_valid_i  = 1'b0;
        slv_aw_i       = '0;
        slv_w_i        = '0;
        drop_expected  = 1'b0;
    endtask

    task automatic wait_idle();
        while ((r_rd_ptr != r_wr_ptr) || (b_rd_ptr != b_wr_ptr)) begin
            @(negedge clk_i);
        end
        @(negedge clk_i);
    endtask

    task automatic close_test(input string name);
        wait_idle();
        test_count++;
        if (error_count == errors_before) begin
            pass_count++;
            $display("Test %0d %s: ok", test_count, name);
        end else begin
            $display("Test %0d %s: FAILED with %0d errors", test_count, name,
                     error_count - errors_before);
        end
        errors_before = error_count;
    endtask

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    initial begin
        repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk_i);
        $display("Watchdog expired before all tests completed");
        $display("Test failures found");
        $finish;
    end

    initial begin
        void'($urandom(35));
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]     = fill_word(i);
            ref_mem[i] = fill_word(i);
        end
        for (int i = 0; i < 4; i++) begin
            res_valid[i] = 1'b0;
            res_word[i]  = '0;
        end
        rst_ni         = 1'b0;
        slv_ar_i       = '0;
        slv_ar_valid_i = 1'b0;
        slv_aw_i       = '0;
        slv_aw_valid_i = 1'b0;
        slv_w_i        = '0;
        slv_w_valid_i  = 1'b0;
        slv_r_ready_i  = 1'b0;
        slv_b_ready_i  = 1'b0;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        read_word(2'd0, 16'h1100, 1'b1);
        read_word(2'd1, 16'h1104, 1'b0);
        read_word(2'd2, 16'h0200, 1'b1);
        close_test("reads");

        read_word(2'd1, 16'h1200, 1'b1);
        wait_idle();
        write_word(2'd1, 16'h1200, 1'b1, $urandom());
        wait_idle();
        read_word(2'd1, 16'h1200, 1'b0);
        close_test("store-conditional success");

        write_word(2'd2, 16'h1300, 1'b1, $urandom());
        wait_idle();
        read_word(2'd2, 16'h1300, 1'b0);
        close_test("store-conditional without reservation");

        read_word(2'd0, 16'h1400, 1'b1);
        wait_idle();
        write_word(2'd1, 16'h1400, 1'b0, $urandom());
        wait_idle();
        write_word(2'd0, 16'h1400, 1'b1, $urandom());
        wait_idle();
        read_word(2'd0, 16'h1400, 1'b0);
        close_test("reservation cleared by other write");

        read_word(2'd3, ERR_ADDR, 1'b1);
        wait_idle();
        write_word(2'd3, ERR_ADDR, 1'b1, $urandom());
        close_test("error pass-through");

        read_word(2'd0, 16'h1500, 1'b1);
        read_word(2'd1, 16'h1504, 1'b1);
        wait_idle();
        // Forwarded and injected responses mixed back to back
        write_word(2'd0, 16'h1500, 1'b1, $urandom());
        write_word(2'd2, 16'h1508, 1'b1, $urandom());
        write_word(2'd3, 16'h0300, 1'b0, $urandom());
        write_word(2'd1, 16'h1504, 1'b1, $urandom());
        write_word(2'd0, 16'h1500, 1'b1, $urandom());
        write_word(2'd1, 16'h1600, 1'b0, $urandom());
        wait_idle();
        read_word(2'd2, 16'h1500, 1'b0);
        read_word(2'd3, 16'h1504, 1'b0);
        close_test("response ordering");

        $display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
                 test_count, pass_count, test_count - pass_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* src/lrsc_adapter.sv */
`timescale 1ns/1ns

module lrsc_adapter
    import axi_chan_pkg::*;
    import lrsc_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_ni,
    // Upstream master side
    input  ar_chan_t slv_ar_i,
    input  logic     slv_ar_valid_i,
    output logic     slv_ar_ready_o,
    input  aw_chan_t slv_aw_i,
    input  logic     slv_aw_valid_i,
    output logic     slv_aw_ready_o,
    input  w_chan_t  slv_w_i,
    input  logic     slv_w_valid_i,
    output logic     slv_w_ready_o,
    output r_chan_t  slv_r_o,
    output logic     slv_r_valid_o,
    input  logic     slv_r_ready_i,
    output b_chan_t  slv_b_o,
    output logic     slv_b_valid_o,
    input  logic     slv_b_ready_i,
    // Memory slave side
    output ar_chan_t mst_ar_o,
    output logic     mst_ar_valid_o,
    input  logic     mst_ar_ready_i,
    output aw_chan_t mst_aw_o,
    output logic     mst_aw_valid_o,
    input  logic     mst_aw_ready_i,
    output w_chan_t  mst_w_o,
    output logic     mst_w_valid_o,
    input  logic     mst_w_ready_i,
    input  r_chan_t  mst_r_i,
    input  logic     mst_r_valid_i,
    output logic     mst_r_ready_o,
    input  b_chan_t  mst_b_i,
    input  logic     mst_b_valid_i,
    output logic     mst_b_ready_o
);

    logic       res_set;
    id_t        res_set_id;
    word_addr_t res_set_addr;
    logic       res_wr;
    id_t        res_wr_id;
    word_addr_t res_wr_addr;
    logic       res_match;
    logic       b_push;
    b_entry_t   b_entry;
    logic       b_full;

    res_table i_res_table (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .set_i      (res_set),
        .set_id_i   (res_set_id),
        .set_addr_i (res_set_addr),
        .wr_i       (res_wr),
        .wr_id_i    (res_wr_id),
        .wr_addr_i  (res_wr_addr),
        .wr_match_o (res_match)
    );

    read_path i_read_path (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .slv_ar_i       (slv_ar_i),
        .slv_ar_valid_i (slv_ar_valid_i),
        .slv_ar_ready_o (slv_ar_ready_o),
        .mst_ar_o       (mst_ar_o),
        .mst_ar_valid_o (mst_ar_valid_o),
        .mst_ar_ready_i (mst_ar_ready_i),
        .mst_r_i        (mst_r_i),
        .mst_r_valid_i  (mst_r_valid_i),
        .mst_r_ready_o  (mst_r_ready_o),
        .slv_r_o        (slv_r_o),
        .slv_r_valid_o  (slv_r_valid_o),
        .slv_r_ready_i  (slv_r_ready_i),
        .res_set_o      (res_set),
        .res_set_id_o   (res_set_id),
        .res_set_addr_o (res_set_addr)
    );

    write_path i_write_path (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .slv_aw_i       (slv_aw_i),
        .slv_aw_valid_i (slv_aw_valid_i),
        .slv_aw_ready_o (slv_aw_ready_o),
        .slv_w_i        (slv_w_i),
        .slv_w_valid_i  (slv_w_valid_i),
        .slv_w_ready_o  (slv_w_ready_o),
        .mst_aw_o       (mst_aw_o),
        .mst_aw_valid_o (mst_aw_valid_o),
        .mst_aw_ready_i (mst_aw_ready_i),
        .mst_w_o        (mst_w_o),
        .mst_w_valid_o  (mst_w_valid_o),
        .mst_w_ready_i  (mst_w_ready_i),
        .res_wr_o       (res_wr),
        .res_wr_id_o    (res_wr_id),
        .res_wr_addr_o  (res_wr_addr),
        .res_match_i    (res_match),
        .b_push_o       (b_push),
        .b_entry_o      (b_entry),
        .b_full_i       (b_full)
    );

    resp_merge i_resp_merge (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .b_push_i      (b_push),
        .b_entry_i     (b_entry),
        .b_full_o      (b_full),
        .mst_b_i       (mst_b_i),
        .mst_b_valid_i (mst_b_valid_i),
        .mst_b_ready_o (mst_b_ready_o),
        .slv_b_o       (slv_b_o),
        .slv_b_valid_o (slv_b_valid_o),
        .slv_b_ready_i (slv_b_ready_i)
    );

endmodule

/* src/resp_merge.sv */
`timescale 1ns/1ns
`include "lrsc_settings.svh"

module resp_merge
    import axi_chan_pkg::*;
    import lrsc_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     b_push_i,
    input  b_entry_t b_entry_i,
    output logic     b_full_o,
    input  b_chan_t  mst_b_i,
    input  logic     mst_b_valid_i,
    output logic     mst_b_ready_o,
    output b_chan_t  slv_b_o,
    output logic     slv_b_valid_o,
    input  logic     slv_b_ready_i
);

    b_entry_t head;
    logic     fifo_empty;
    logic     inject;
    logic     fwd;
    logic     pop;

    sync_fifo #(
        .DEPTH  (`LRSC_MAX_TXNS),
        .elem_t (b_entry_t)
    ) i_b_cmds (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (b_push_i),
        .data_i  (b_entry_i),
        .full_o  (b_full_o),
        .pop_i   (pop),
        .data_o  (head),
        .empty_o (fifo_empty)
    );

    // Head decides whose turn it is, which keeps acceptance order
    assign inject = !fifo_empty && (head.cmd == B_INJECT);
    assign fwd    = !fifo_empty && (head.cmd != B_INJECT);

    assign slv_b_valid_o = inject || (fwd && mst_b_valid_i);
    assign mst_b_ready_o = fwd && slv_b_ready_i;
    assign pop           = slv_b_valid_o && slv_b_ready_i;

    always_comb begin
        if (inject) begin
            slv_b_o.id   = head.id;
            slv_b_o.resp = OKAY;
        end else begin
            slv_b_o.id   = mst_b_i.id;
            slv_b_o.resp = upgrade_resp(mst_b_i.resp, head.cmd == B_EXCLUSIVE);
        end
    end

    a_b_expected: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mst_b_valid_i |-> !fifo_empty)
        else $error("resp_merge: B without an accepted write");

    // Slave answers in order, so its id must match the oldest forwarded write
    a_b_in_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (fwd && mst_b_valid_i) |-> (mst_b_i.id == head.id))
        else $error("resp_merge: B id out of order");

endmodule

/* src/write_path.sv */
`timescale 1ns/1ns

module write_path
    import axi_chan_pkg::*;
    import lrsc_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,
    input  aw_chan_t   slv_aw_i,
    input  logic       slv_aw_valid_i,
    output logic       slv_aw_ready_o,
    input  w_chan_t    slv_w_i,
    input  logic       slv_w_valid_i,
    output logic       slv_w_ready_o,
    output aw_chan_t   mst_aw_o,
    output logic       mst_aw_valid_o,
    input  logic       mst_aw_ready_i,
    output w_chan_t    mst_w_o,
    output logic       mst_w_valid_o,
    input  logic       mst_w_ready_i,
    output logic       res_wr_o,
    output id_t        res_wr_id_o,
    output word_addr_t res_wr_addr_o,
    input  logic       res_match_i,
    output logic       b_push_o,
    output b_entry_t   b_entry_o,
    input  logic       b_full_i
);

    logic both_valid;
    logic in_range;
    logic excl;
    logic drop;
    logic fwd_ready;
    logic accept;

    assign both_valid = slv_aw_valid_i && slv_w_valid_i;
    assign in_range   = in_excl_range(slv_aw_i.addr);
    assign excl       = slv_aw_i.lock && in_range;
    // SC without a live reservation never reaches memory
    assign drop       = excl && !res_match_i;
    assign fwd_ready  = mst_aw_ready_i && mst_w_ready_i;

    always_comb begin
        mst_aw_o      = slv_aw_i;
        mst_aw_o.lock = 1'b0;
    end
    assign mst_w_o = slv_w_i;

    assign mst_aw_valid_o = both_valid && !drop && !b_full_i;
    assign mst_w_valid_o  = mst_aw_valid_o;

    // AW and W are only ever taken together
    assign accept         = both_valid && !b_full_i && (drop || fwd_ready);
    assign slv_aw_ready_o = accept;
    assign slv_w_ready_o  = accept;

    assign res_wr_o      = accept && in_range;
    assign res_wr_id_o   = slv_aw_i.id;
    assign res_wr_addr_o = to_word_addr(slv_aw_i.addr);

    assign b_push_o     = accept;
    assign b_entry_o.id = slv_aw_i.id;

    always_comb begin
        if (drop) begin
            b_entry_o.cmd = B_INJECT;
        end else if (excl) begin
            b_entry_o.cmd = B_EXCLUSIVE;
        end else begin
            b_entry_o.cmd = B_REGULAR;
        end
    end

    a_readies_agree: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mst_aw_valid_o |-> (mst_aw_ready_i == mst_w_ready_i))
        else $error("write_path: slave AW and W readies differ");

endmodule

/* src/read_path.sv */
`timescale 1ns/1ns
`include "lrsc_settings.svh"

module read_path
    import axi_chan_pkg::*;
    import lrsc_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,
    input  ar_chan_t   slv_ar_i,
    input  logic       slv_ar_valid_i,
    output logic       slv_ar_ready_o,
    output ar_chan_t   mst_ar_o,
    output logic       mst_ar_valid_o,
    input  logic       mst_ar_ready_i,
    input  r_chan_t    mst_r_i,
    input  logic       mst_r_valid_i,
    output logic       mst_r_ready_o,
    output r_chan_t    slv_r_o,
    output logic       slv_r_valid_o,
    input  logic       slv_r_ready_i,
    output logic       res_set_o,
    output id_t        res_set_id_o,
    output word_addr_t res_set_addr_o
);

    logic ar_excl;
    logic ar_hs;
    logic r_hs;
    logic flag_full;
    logic flag_empty;
    logic flag_head;

    // Slave never sees a locked access
    always_comb begin
        mst_ar_o      = slv_ar_i;
        mst_ar_o.lock = 1'b0;
    end

    assign ar_excl        = slv_ar_i.lock && in_excl_range(slv_ar_i.addr);
    assign mst_ar_valid_o = slv_ar_valid_i && !flag_full;
    assign slv_ar_ready_o = mst_ar_ready_i && !flag_full;
    assign ar_hs          = slv_ar_valid_i && slv_ar_ready_o;

    assign res_set_o      = ar_hs && ar_excl;
    assign res_set_id_o   = slv_ar_i.id;
    assign res_set_addr_o = to_word_addr(slv_ar_i.addr);

    // One flag per outstanding read, reads complete in order
    sync_fifo #(
        .DEPTH  (`LRSC_MAX_TXNS),
        .elem_t (logic)
    ) i_excl_flags (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (ar_hs),
        .data_i  (ar_excl),
        .full_o  (flag_full),
        .pop_i   (r_hs),
        .data_o  (flag_head),
        .empty_o (flag_empty)
    );

    assign slv_r_valid_o = mst_r_valid_i;
    assign mst_r_ready_o = slv_r_ready_i;
    assign r_hs          = mst_r_valid_i && slv_r_ready_i;

    always_comb begin
        slv_r_o      = mst_r_i;
        slv_r_o.resp = upgrade_resp(mst_r_i.resp, flag_head);
    end

    a_r_has_flag: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mst_r_valid_i |-> !flag_empty)
        else $error("read_path: R without outstanding AR");

endmodule

/* src/res_table.sv */
`timescale 1ns/1ns

module res_table
    import axi_chan_pkg::*;
    import lrsc_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       set_i,
    input  id_t        set_id_i,
    input  word_addr_t set_addr_i,
    input  logic       wr_i,
    input  id_t        wr_id_i,
    input  word_addr_t wr_addr_i,
    output logic       wr_match_o
);

    localparam int unsigned NUM_IDS = 2 ** $bits(id_t);

    logic [NUM_IDS-1:0] valid_q;
    word_addr_t         addr_q [NUM_IDS];

    // Looks at the entry as it stands before this cycle's clear
    assign wr_match_o = valid_q[wr_id_i] && (addr_q[wr_id_i] == wr_addr_i);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else begin
            // Any write to the word kills every reservation on it
            for (int i = 0; i < NUM_IDS; i++) begin
                if (wr_i && (addr_q[i] == wr_addr_i)) begin
                    valid_q[i] <= 1'b0;
                end
            end
            // A new reservation overrides a clear in the same cycle
            if (set_i) begin
                valid_q[set_id_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (set_i) begin
            addr_q[set_id_i] <= set_addr_i;
        end
    end

endmodule

/* src/sync_fifo.sv */
`timescale 1ns/1ns

module sync_fifo #(
    parameter int unsigned DEPTH = 4,
    parameter type elem_t = logic
) (
    input  logic  clk_i,
    input  logic  rst_ni,
    input  logic  push_i,
    input  elem_t data_i,
    output logic  full_o,
    input  logic  pop_i,
    output elem_t data_o,
    output logic  empty_o
);

    localparam int unsigned PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_WIDTH = $clog2(DEPTH + 1);

    typedef logic [PTR_WIDTH-1:0] ptr_t;

    elem_t                mem_q [DEPTH];
    ptr_t                 wr_ptr_q;
    ptr_t                 rd_ptr_q;
    logic [CNT_WIDTH-1:0] count_q;

    function automatic ptr_t next_ptr(ptr_t ptr);
        return (ptr == ptr_t'(DEPTH - 1)) ? '0 : ptr + ptr_t'(1);
    endfunction

    assign full_o  = (count_q == CNT_WIDTH'(DEPTH));
    assign empty_o = (count_q == '0);
    // Head is visible without a pop
    assign data_o  = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop_i) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            if (push_i && !pop_i) begin
                count_q <= count_q + CNT_WIDTH'(1);
            end else if (pop_i && !push_i) begin
                count_q <= count_q - CNT_WIDTH'(1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_i |-> !full_o)
        else $error("sync_fifo: push while full");

    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_i |-> !empty_o)
        else $error("sync_fifo: pop while empty");

endmodule

/* src/lrsc_pkg.sv */
`include "lrsc_settings.svh"

package lrsc_pkg;

    import axi_chan_pkg::*;

    // Reservations are tracked per word
    typedef logic [$bits(addr_t)-1:2] word_addr_t;

    typedef enum logic [1:0] {
        B_REGULAR,
        B_EXCLUSIVE,
        B_INJECT
    } b_cmd_e;

    // One entry per accepted write, popped when its B leaves
    typedef struct packed {
        b_cmd_e cmd;
        id_t    id;
    } b_entry_t;

    function automatic logic in_excl_range(addr_t addr);
        return (addr >= addr_t'(`LRSC_EXCL_BEGIN)) && (addr <= addr_t'(`LRSC_EXCL_END));
    endfunction

    function automatic word_addr_t to_word_addr(addr_t addr);
        return addr[$bits(addr_t)-1:2];
    endfunction

    // Error responses are never touched
    function automatic resp_e upgrade_resp(resp_e resp, logic excl);
        return (excl && (resp == OKAY)) ? EXOKAY : resp;
    endfunction

endpackage

/* src/axi_chan_pkg.sv */
`include "lrsc_settings.svh"

package axi_chan_pkg;

    localparam int unsigned STRB_WIDTH = `LRSC_DATA_WIDTH / 8;

    typedef logic [`LRSC_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`LRSC_DATA_WIDTH-1:0] data_t;
    typedef logic [`LRSC_ID_WIDTH-1:0]   id_t;
    typedef logic [STRB_WIDTH-1:0]       strb_t;

    // Response encoding as on the bus
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_e;

    typedef struct packed {
        addr_t addr;
        id_t   id;
        logic  lock;
    } ar_chan_t;

    typedef struct packed {
        addr_t addr;
        id_t   id;
        logic  lock;
    } aw_chan_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
    } w_chan_t;

    typedef struct packed {
        data_t data;
        id_t   id;
        resp_e resp;
    } r_chan_t;

    typedef struct packed {
        id_t   id;
        resp_e resp;
    } b_chan_t;

endpackage

/* src/lrsc_settings.svh */
`ifndef LRSC_SETTINGS_SVH
`define LRSC_SETTINGS_SVH

// Bus widths
`define LRSC_ADDR_WIDTH 16
`define LRSC_DATA_WIDTH 32
`define LRSC_ID_WIDTH 2

// Closed byte-address range where exclusive accesses are honoured
`define LRSC_EXCL_BEGIN 16'h1000
`define LRSC_EXCL_END 16'h1FFF

// Depth of the read-flag and B-command FIFOs
`define LRSC_MAX_TXNS 4

`endif
